// ==== all.f ====
logic/dispatch_pkg.sv
logic/dispatch_cmd_capture.sv
logic/batch_sequencer.sv
logic/copy_pipeline.sv
logic/dispatcher_top.sv
bench/dispatcher_assertions.sv
bench/dispatcher_tb.sv

// ==== bench/dispatcher_tb.sv ====
// Dispatcher testbench running distribute, single tile, broadcast and retrigger commands
`timescale 1ns/1ns

module dispatcher_tb;

    import dispatch_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_CMDS = 3;
    localparam int MEM_LINES = 1 << ADDR_WIDTH;
    // Enable handling after the read stream starts
    localparam int MODE_RELEASE = 0;
    localparam int MODE_HOLD = 1;
    localparam int MODE_PULSE = 2;

    logic                  i_clk;
    logic                  i_reset_n;
    logic                  i_disp_en;
    logic [ADDR_WIDTH-1:0] i_disp_tile_addr;
    logic [NV_CNT_WIDTH-1:0] i_disp_man_nv_cnt;
    logic [NV_CNT_WIDTH-1:0] i_disp_ugd_vec_size;
    logic [NUM_TILES-1:0]  i_disp_col_en;
    logic                  i_disp_broadcast;
    logic [MAN_WIDTH-1:0]  i_rd_man_data;
    logic [EXP_WIDTH-1:0]  i_rd_exp_data;
    logic                  o_disp_done;
    logic                  o_rd_en;
    logic [ADDR_WIDTH-1:0] o_rd_addr;
    logic                  o_wr_en;
    logic [ADDR_WIDTH-1:0] o_wr_addr;
    logic [MAN_WIDTH-1:0]  o_wr_man_data;
    logic [EXP_WIDTH-1:0]  o_wr_exp_data;
    logic [NUM_TILES-1:0]  o_tile_wr_en;

    // Commands: distribute over 3 tiles, single tile, broadcast to 2 tiles
    int                   cmd_nv   [NUM_CMDS] = '{8, 6, 4};
    int                   cmd_vec  [NUM_CMDS] = '{2, 3, 1};
    logic [NUM_TILES-1:0] cmd_mask [NUM_CMDS] = '{24'h7, 24'h1, 24'h3};
    bit                   cmd_bc   [NUM_CMDS] = '{1'b0, 1'b0, 1'b1};
    int                   cmd_base [NUM_CMDS] = '{16, 100, 200};

    // Source memory contents
    logic [MAN_WIDTH-1:0] src_man [MEM_LINES];
    logic [EXP_WIDTH-1:0] src_exp [MEM_LINES];
    // Read issued in the previous cycle
    logic                  rd_pending;
    logic [ADDR_WIDTH-1:0] rd_addr_q;
    // Expected writes in order
    logic [ADDR_WIDTH-1:0] exp_src_q [$];
    logic [ADDR_WIDTH-1:0] exp_dst_q [$];
    logic [NUM_TILES-1:0]  exp_tile_q [$];
    logic [31:0] lcg_state;
    int error_count;
    int read_count;
    int write_count;
    bit cmd_issued;

    dispatcher_top u_dispatcher_top (.*);

    // ========================================
    // Clock and helpers
    // ========================================
    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // T lines per command, repeated N times in broadcast
    function automatic int total_lines(input int idx);
        int reps;
        reps = cmd_bc[idx] ? $countones(cmd_mask[idx]) : 1;
        return cmd_vec[idx] * LINES_PER_NV * (cmd_nv[idx] / cmd_vec[idx]) * reps;
    endfunction

    task automatic fill_source_memory();
        for (int a = 0; a < MEM_LINES; a++) begin
            for (int w = 0; w < MAN_WIDTH / 32; w++) begin
                lcg_state = lcg_next(lcg_state);
                src_man[a][w*32 +: 32] = lcg_state;
            end
            // Address folded into the low word and the exponent
            src_man[a][31:0] = src_man[a][31:0] ^ a;
            lcg_state = lcg_next(lcg_state);
            src_exp[a] = lcg_state[23:16] ^ a[7:0] ^ {7'd0, a[8]};
        end
    endtask

    task automatic push_batch(input int src, input int dst, input int lines,
                              input logic [NUM_TILES-1:0] tiles);
        for (int l = 0; l < lines; l++) begin
            exp_src_q.push_back(ADDR_WIDTH'(src + l));
            exp_dst_q.push_back(ADDR_WIDTH'(dst + l));
            exp_tile_q.push_back(tiles);
        end
    endtask

    // ========================================
    // Reference model of the batch walk
    // ========================================
    task automatic build_expected(input int idx);
        int n;
        int lines;
        int batches;
        int src;
        int dst;
        int tile;
        n = $countones(cmd_mask[idx]);
        lines = cmd_vec[idx] * LINES_PER_NV;
        batches = cmd_nv[idx] / cmd_vec[idx];
        src = 0;
        dst = cmd_base[idx];
        tile = 0;
        for (int b = 0; b < batches; b++) begin
            if (cmd_bc[idx]) begin
                // Same batch repeated once per enabled column
                for (int r = 0; r < n; r++) begin
                    push_batch(src, dst, lines, cmd_mask[idx]);
                end
                dst += lines;
            end else begin
                push_batch(src, dst, lines, NUM_TILES'(1) << tile);
                tile++;
                // Next destination row once every tile got a batch
                if (tile == n) begin
                    tile = 0;
                    dst += lines;
                end
            end
            src += lines;
        end
    endtask

    task automatic run_dispatch(input int idx, input int mode);
        int lines;
        int reads_before;
        int writes_before;
        lines = total_lines(idx);
        build_expected(idx);
        reads_before = read_count;
        writes_before = write_count;
        @(negedge i_clk);
        i_disp_tile_addr = ADDR_WIDTH'(cmd_base[idx]);
        i_disp_man_nv_cnt = NV_CNT_WIDTH'(cmd_nv[idx]);
        i_disp_ugd_vec_size = NV_CNT_WIDTH'(cmd_vec[idx]);
        i_disp_col_en = cmd_mask[idx];
        i_disp_broadcast = cmd_bc[idx];
        i_disp_en = 1'b1;
        cmd_issued = 1'b1;
        do @(negedge i_clk); while (!o_rd_en);
        if (mode == MODE_PULSE) begin
            // Fresh edge while busy must be dropped
            @(negedge i_clk) i_disp_en = 1'b0;
            @(negedge i_clk) i_disp_en = 1'b1;
            @(negedge i_clk) i_disp_en = 1'b0;
        end else if (mode == MODE_RELEASE) begin
            i_disp_en = 1'b0;
        end
        while (!o_disp_done) @(negedge i_clk);
        if (mode == MODE_HOLD) begin
            repeat (4) begin
                @(negedge i_clk);
                assert (!o_rd_en && o_disp_done) else begin
                    $display("Dispatch restarted with the enable held high at %0t", $time);
                    error_count++;
                end
            end
            i_disp_en = 1'b0;
        end
        assert (read_count - reads_before == lines) else begin
            $display("Fail %0t read count expected %0d actual %0d", $time, lines,
                     read_count - reads_before);
            error_count++;
        end
        assert (write_count - writes_before == lines) else begin
            $display("Fail %0t write count expected %0d actual %0d", $time, lines,
                     write_count - writes_before);
            error_count++;
        end
        assert (exp_src_q.size() == 0) else begin
            $display("Command %0d ended with %0d writes missing", idx, exp_src_q.size());
            error_count++;
        end
    endtask

    // ========================================
    // Source memory, one cycle read latency
    // ========================================
    always @(negedge i_clk) begin
        if (rd_pending) begin
            i_rd_man_data = src_man[rd_addr_q];
            i_rd_exp_data = src_exp[rd_addr_q];
        end
        rd_pending = o_rd_en;
        rd_addr_q = o_rd_addr;
    end

    // ========================================
    // Write checks against the reference queues
    // ========================================
    always @(posedge i_clk) begin : write_check
        logic [ADDR_WIDTH-1:0] src;
        logic [ADDR_WIDTH-1:0] dst;
        logic [NUM_TILES-1:0]  tiles;
        if (i_reset_n && o_rd_en) begin
            read_count++;
        end
        if (i_reset_n && o_wr_en) begin
            write_count++;
            if (exp_src_q.size() == 0) begin
                $display("Write at %0t when no write was expected", $time);
                error_count++;
            end else begin
                src = exp_src_q.pop_front();
                dst = exp_dst_q.pop_front();
                tiles = exp_tile_q.pop_front();
                assert (o_wr_addr == dst) else begin
                    $display("Fail %0t o_wr_addr expected %h actual %h", $time, dst, o_wr_addr);
                    error_count++;
                end
                assert (o_tile_wr_en == tiles) else begin
                    $display("Fail %0t o_tile_wr_en expected %h actual %h", $time, tiles,
                             o_tile_wr_en);
                    error_count++;
                end
                assert (o_wr_man_data == src_man[src]) else begin
                    $display("Fail %0t o_wr_man_data expected %h actual %h", $time,
                             src_man[src], o_wr_man_data);
                    error_count++;
                end
                assert (o_wr_exp_data == src_exp[src]) else begin
                    $display("Fail %0t o_wr_exp_data expected %h actual %h", $time,
                             src_exp[src], o_wr_exp_data);
                    error_count++;
                end
            end
        end
        // Outputs stay quiet until the first command
        if (i_reset_n && !cmd_issued) begin
            assert (!o_rd_en && !o_wr_en && o_tile_wr_en == '0 && !o_disp_done) else begin
                $display("Outputs active before the first command at %0t", $time);
                error_count++;
            end
        end
    end

    initial begin : watchdog
        int limit;
        limit = 10;
        for (int i = 0; i < NUM_CMDS; i++) begin
            limit += total_lines(i) + 50;
        end
        #(limit * CLK_PERIOD);
        $display("Timeout after %0d cycles, a dispatch never finished", limit);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        i_clk = 1'b0;
        i_reset_n = 1'b0;
        i_disp_en = 1'b0;
        i_disp_tile_addr = '0;
        i_disp_man_nv_cnt = '0;
        i_disp_ugd_vec_size = '0;
        i_disp_col_en = '0;
        i_disp_broadcast = 1'b0;
        i_rd_man_data = '0;
        i_rd_exp_data = '0;
        rd_pending = 1'b0;
        rd_addr_q = '0;
        error_count = 0;
        read_count = 0;
        write_count = 0;
        cmd_issued = 1'b0;
        lcg_state = 32'h2baa;
        fill_source_memory();
        repeat (2) @(negedge i_clk);
        i_reset_n = 1'b1;
        repeat (3) @(negedge i_clk);
        run_dispatch(0, MODE_HOLD);
        run_dispatch(1, MODE_PULSE);
        run_dispatch(2, MODE_RELEASE);
        repeat (3) @(negedge i_clk);
        $display("Reads %0d, writes %0d, check errors %0d, assertion failures %0d",
                 read_count, write_count, error_count,
                 u_dispatcher_top.u_dispatcher_assertions.fail_count);
        if (error_count == 0 && u_dispatcher_top.u_dispatcher_assertions.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : dispatcher_tb

// ==== bench/dispatcher_assertions.sv ====
// Timing assertions for dispatcher read, write and done sequencing
`timescale 1ns/1ns

module dispatcher_assertions (
    input logic                               i_clk,
    input logic                               i_reset_n,
    input logic                               i_rd_en,
    input logic                               i_wr_en,
    input logic [dispatch_pkg::NUM_TILES-1:0] i_tile_wr_en,
    input logic                               i_disp_done
);

    // Number of failed checks
    int fail_count = 0;

    // ========================================
    // Reset and write alignment
    // ========================================
    reset_quiet: assert property (@(posedge i_clk) !i_reset_n |=>
        (!i_rd_en && !i_wr_en && i_tile_wr_en == '0 && !i_disp_done))
    else begin
        $error("Outputs active right after reset");
        fail_count++;
    end

    // Write one cycle behind its read
    write_follows_read: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_wr_en == $past(i_rd_en))
    else begin
        $error("Write not one cycle behind its read");
        fail_count++;
    end

    tile_en_with_write: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (i_tile_wr_en != '0) == i_wr_en)
    else begin
        $error("Tile enable does not match the write strobe");
        fail_count++;
    end

    // ========================================
    // Done and read stream
    // ========================================
    done_after_last_write: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        $fell(i_wr_en) |-> $rose(i_disp_done))
    else begin
        $error("Done did not rise one cycle after the last write");
        fail_count++;
    end

    // A gap in the reads before the end shows up as a missing done
    reads_continuous: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        $fell(i_rd_en) |=> i_disp_done)
    else begin
        $error("Read stream stopped before the dispatch ended");
        fail_count++;
    end

    done_held: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_disp_done |=> (i_disp_done || i_rd_en))
    else begin
        $error("Done dropped without a new dispatch");
        fail_count++;
    end

    // New dispatch clears done as reads start
    start_clears_done: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        $rose(i_rd_en) |-> !i_disp_done)
    else begin
        $error("Done still high while a new dispatch reads");
        fail_count++;
    end

endmodule : dispatcher_assertions

bind dispatcher_top dispatcher_assertions u_dispatcher_assertions (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_rd_en      (o_rd_en),
    .i_wr_en      (o_wr_en),
    .i_tile_wr_en (o_tile_wr_en),
    .i_disp_done  (o_disp_done)
);

// ==== logic/dispatcher_top.sv ====
// Dispatcher top level joining command capture, batch sequencer and copy pipeline
`timescale 1ns/1ns

module dispatcher_top (
    input  logic                                i_clk,
    input  logic                                i_reset_n,
    // Dispatch command
    input  logic                                i_disp_en,
    input  logic [dispatch_pkg::ADDR_WIDTH-1:0]   i_disp_tile_addr,
    input  logic [dispatch_pkg::NV_CNT_WIDTH-1:0] i_disp_man_nv_cnt,
    input  logic [dispatch_pkg::NV_CNT_WIDTH-1:0] i_disp_ugd_vec_size,
    input  logic [dispatch_pkg::NUM_TILES-1:0]    i_disp_col_en,
    input  logic                                i_disp_broadcast,
    output logic                                o_disp_done,
    // Dispatcher memory read port
    output logic                                o_rd_en,
    output logic [dispatch_pkg::ADDR_WIDTH-1:0] o_rd_addr,
    input  logic [dispatch_pkg::MAN_WIDTH-1:0]  i_rd_man_data,
    input  logic [dispatch_pkg::EXP_WIDTH-1:0]  i_rd_exp_data,
    // Tile memory write port
    output logic                                o_wr_en,
    output logic [dispatch_pkg::ADDR_WIDTH-1:0] o_wr_addr,
    output logic [dispatch_pkg::MAN_WIDTH-1:0]  o_wr_man_data,
    output logic [dispatch_pkg::EXP_WIDTH-1:0]  o_wr_exp_data,
    output logic [dispatch_pkg::NUM_TILES-1:0]  o_tile_wr_en
);

    import dispatch_pkg::*;

    // Capture to sequencer
    logic                      start;
    logic                      idle;
    logic [LINE_CNT_WIDTH-1:0] batch_lines;
    logic [NV_CNT_WIDTH-1:0]   total_batches;
    logic [TILE_IDX_WIDTH:0]   num_tiles;
    logic [NUM_TILES-1:0]      col_en;
    logic                      broadcast;
    logic [ADDR_WIDTH-1:0]     dest_base;
    // Sequencer to pipeline
    logic                      busy;
    logic [ADDR_WIDTH-1:0]     seq_rd_addr;
    logic [ADDR_WIDTH-1:0]     seq_wr_addr;
    logic [NUM_TILES-1:0]      tile_en;

    // ========================================
    // Command capture
    // ========================================
    dispatch_cmd_capture u_cmd_capture (
        .i_clk               (i_clk),
        .i_reset_n           (i_reset_n),
        .i_disp_en           (i_disp_en),
        .i_disp_tile_addr    (i_disp_tile_addr),
        .i_disp_man_nv_cnt   (i_disp_man_nv_cnt),
        .i_disp_ugd_vec_size (i_disp_ugd_vec_size),
        .i_disp_col_en       (i_disp_col_en),
        .i_disp_broadcast    (i_disp_broadcast),
        .i_idle              (idle),
        .o_start             (start),
        .o_batch_lines       (batch_lines),
        .o_total_batches     (total_batches),
        .o_num_tiles         (num_tiles),
        .o_col_en            (col_en),
        .o_broadcast         (broadcast),
        .o_dest_base         (dest_base)
    );

    // ========================================
    // Sequencer
    // ========================================
    batch_sequencer u_batch_sequencer (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_start         (start),
        .i_batch_lines   (batch_lines),
        .i_total_batches (total_batches),
        .i_num_tiles     (num_tiles),
        .i_col_en        (col_en),
        .i_broadcast     (broadcast),
        .i_dest_base     (dest_base),
        .o_idle          (idle),
        .o_busy          (busy),
        .o_rd_addr       (seq_rd_addr),
        .o_wr_addr       (seq_wr_addr),
        .o_tile_en       (tile_en),
        .o_disp_done     (o_disp_done)
    );

    // ========================================
    // Memory side pipeline
    // ========================================
    // A read is requested on every busy cycle
    copy_pipeline u_copy_pipeline (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_rd_req      (busy),
        .i_rd_addr     (seq_rd_addr),
        .i_wr_addr     (seq_wr_addr),
        .i_tile_en     (tile_en),
        .i_rd_man_data (i_rd_man_data),
        .i_rd_exp_data (i_rd_exp_data),
        .o_rd_en       (o_rd_en),
        .o_rd_addr     (o_rd_addr),
        .o_wr_en       (o_wr_en),
        .o_wr_addr     (o_wr_addr),
        .o_wr_man_data (o_wr_man_data),
        .o_wr_exp_data (o_wr_exp_data),
        .o_tile_wr_en  (o_tile_wr_en)
    );

endmodule : dispatcher_top

// ==== logic/copy_pipeline.sv ====
// Copy pipeline issuing memory reads and the tile writes aligned to read latency
`timescale 1ns/1ns

module copy_pipeline (
    input  logic                                i_clk,
    input  logic                                i_reset_n,
    // Copy step from the sequencer
    input  logic                                i_rd_req,
    input  logic [dispatch_pkg::ADDR_WIDTH-1:0] i_rd_addr,
    input  logic [dispatch_pkg::ADDR_WIDTH-1:0] i_wr_addr,
    input  logic [dispatch_pkg::NUM_TILES-1:0]  i_tile_en,
    // Read data one cycle after the request
    input  logic [dispatch_pkg::MAN_WIDTH-1:0]  i_rd_man_data,
    input  logic [dispatch_pkg::EXP_WIDTH-1:0]  i_rd_exp_data,
    // Dispatcher memory read port
    output logic                                o_rd_en,
    output logic [dispatch_pkg::ADDR_WIDTH-1:0] o_rd_addr,
    // Tile memory write port
    output logic                                o_wr_en,
    output logic [dispatch_pkg::ADDR_WIDTH-1:0] o_wr_addr,
    output logic [dispatch_pkg::MAN_WIDTH-1:0]  o_wr_man_data,
    output logic [dispatch_pkg::EXP_WIDTH-1:0]  o_wr_exp_data,
    output logic [dispatch_pkg::NUM_TILES-1:0]  o_tile_wr_en
);

    import dispatch_pkg::*;

    // Write side lags the read side by one stage
    logic                  wr_valid_q;
    logic [ADDR_WIDTH-1:0] wr_addr_q;
    logic [NUM_TILES-1:0]  tile_en_q;

    // ========================================
    // Read side
    // ========================================
    // Request leaves in the same cycle it is made
    assign o_rd_en   = i_rd_req;
    assign o_rd_addr = i_rd_addr;

    // ========================================
    // Write alignment stage
    // ========================================
    // Valid and tile enables follow the request
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            wr_valid_q <= 1'b0;
            tile_en_q  <= '0;
        end else begin
            wr_valid_q <= i_rd_req;
            // No tile is selected in a cycle without a write
            tile_en_q  <= i_rd_req ? i_tile_en : '0;
        end
    end

    // Destination offset delayed with its read
    always_ff @(posedge i_clk) begin
        if (i_rd_req) begin
            wr_addr_q <= i_wr_addr;
        end
    end

    // ========================================
    // Write side
    // ========================================
    assign o_wr_en       = wr_valid_q;
    assign o_wr_addr     = wr_addr_q;
    // Memory output goes to the tiles unchanged
    assign o_wr_man_data = i_rd_man_data;
    assign o_wr_exp_data = i_rd_exp_data;
    assign o_tile_wr_en  = tile_en_q;

endmodule : copy_pipeline

// ==== logic/batch_sequencer.sv ====
// Batch sequencer walking lines, batches and tiles and generating copy addresses
`timescale 1ns/1ns

module batch_sequencer (
    input  logic                                    i_clk,
    input  logic                                    i_reset_n,
    // Captured command
    input  logic                                    i_start,
    input  logic [dispatch_pkg::LINE_CNT_WIDTH-1:0] i_batch_lines,
    input  logic [dispatch_pkg::NV_CNT_WIDTH-1:0]   i_total_batches,
    input  logic [dispatch_pkg::TILE_IDX_WIDTH:0]   i_num_tiles,
    input  logic [dispatch_pkg::NUM_TILES-1:0]      i_col_en,
    input  logic                                    i_broadcast,
    input  logic [dispatch_pkg::ADDR_WIDTH-1:0]     i_dest_base,
    // Status
    output logic                                    o_idle,
    output logic                                    o_busy,
    // One copy step per busy cycle
    output logic [dispatch_pkg::ADDR_WIDTH-1:0]     o_rd_addr,
    output logic [dispatch_pkg::ADDR_WIDTH-1:0]     o_wr_addr,
    output logic [dispatch_pkg::NUM_TILES-1:0]      o_tile_en,
    output logic                                    o_disp_done
);

    import dispatch_pkg::*;

    logic [STATE_WIDTH-1:0]    state;
    logic [LINE_CNT_WIDTH-1:0] line_cnt;
    logic [NV_CNT_WIDTH-1:0]   batch_cnt;
    logic [TILE_IDX_WIDTH-1:0] tile_idx;
    logic [TILE_IDX_WIDTH:0]   tile_next;
    // Source pointer in the dispatcher memory
    logic [ADDR_WIDTH-1:0]     src_ptr;
    // Destination pointer in the tile memories
    logic [ADDR_WIDTH-1:0]     dst_ptr;
    logic [ADDR_WIDTH-1:0]     lines_step;
    logic                      batch_end;
    logic                      tile_wrap;
    logic                      last_batch;
    logic                      last_line;
    logic                      done_q;

    // ========================================
    // Step conditions
    // ========================================
    assign lines_step = i_batch_lines[ADDR_WIDTH-1:0];
    assign tile_next  = {1'b0, tile_idx} + 1'b1;
    assign batch_end  = (line_cnt == i_batch_lines - 1'b1);
    // Also true on every batch when only one tile is enabled
    assign tile_wrap  = (tile_next == i_num_tiles);
    assign last_batch = (batch_cnt == i_total_batches - 1'b1);
    // Broadcast finishes only after the last repetition of the last batch
    assign last_line  = batch_end && last_batch && (tile_wrap || !i_broadcast);

    // ========================================
    // State register
    // ========================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state  <= ST_IDLE;
            done_q <= 1'b0;
        end else begin
            case (state)
                ST_BUSY: begin
                    if (last_line) begin
                        state <= ST_DONE;
                    end
                end
                // Single pass, the flag below keeps done visible
                ST_DONE: begin
                    state  <= ST_IDLE;
                    done_q <= 1'b1;
                end
                default: begin
                    if (i_start) begin
                        state  <= ST_BUSY;
                        done_q <= 1'b0;
                    end
                end
            endcase
        end
    end

    // ========================================
    // Line, batch and tile counters
    // ========================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            line_cnt  <= '0;
            batch_cnt <= '0;
            tile_idx  <= '0;
            src_ptr   <= '0;
            dst_ptr   <= '0;
        end else if (i_start) begin
            line_cnt  <= '0;
            batch_cnt <= '0;
            // Distribution always begins at tile 0
            tile_idx  <= '0;
            src_ptr   <= '0;
            dst_ptr   <= i_dest_base;
        end else if (state == ST_BUSY) begin
            if (batch_end) begin
                line_cnt <= '0;
                tile_idx <= tile_wrap ? '0 : tile_next[TILE_IDX_WIDTH-1:0];
                // Distribute moves on every batch, broadcast after all repetitions
                if (tile_wrap || !i_broadcast) begin
                    src_ptr   <= src_ptr + lines_step;
                    batch_cnt <= batch_cnt + 1'b1;
                end
                // Destination row advances once all tiles got a batch
                if (tile_wrap) begin
                    dst_ptr <= dst_ptr + lines_step;
                end
            end else begin
                line_cnt <= line_cnt + 1'b1;
            end
        end
    end

    // ========================================
    // Outputs
    // ========================================
    assign o_idle      = (state != ST_BUSY);
    assign o_busy      = (state == ST_BUSY);
    assign o_rd_addr   = src_ptr + line_cnt[ADDR_WIDTH-1:0];
    assign o_wr_addr   = dst_ptr + line_cnt[ADDR_WIDTH-1:0];
    // Every enabled column in broadcast, the current tile only otherwise
    assign o_tile_en   = i_broadcast ? i_col_en
                                     : {{(NUM_TILES-1){1'b0}}, 1'b1} << tile_idx;
    assign o_disp_done = done_q;

endmodule : batch_sequencer

// ==== logic/dispatch_cmd_capture.sv ====
// Dispatch command capture detecting the enable edge and registering derived values
`timescale 1ns/1ns

module dispatch_cmd_capture (
    input  logic                                    i_clk,
    input  logic                                    i_reset_n,
    // Command from the controller
    input  logic                                    i_disp_en,
    input  logic [dispatch_pkg::ADDR_WIDTH-1:0]     i_disp_tile_addr,
    input  logic [dispatch_pkg::NV_CNT_WIDTH-1:0]   i_disp_man_nv_cnt,
    input  logic [dispatch_pkg::NV_CNT_WIDTH-1:0]   i_disp_ugd_vec_size,
    input  logic [dispatch_pkg::NUM_TILES-1:0]      i_disp_col_en,
    input  logic                                    i_disp_broadcast,
    // Sequencer can accept a new command
    input  logic                                    i_idle,
    // Captured command toward the sequencer
    output logic                                    o_start,
    output logic [dispatch_pkg::LINE_CNT_WIDTH-1:0] o_batch_lines,
    output logic [dispatch_pkg::NV_CNT_WIDTH-1:0]   o_total_batches,
    output logic [dispatch_pkg::TILE_IDX_WIDTH:0]   o_num_tiles,
    output logic [dispatch_pkg::NUM_TILES-1:0]      o_col_en,
    output logic                                    o_broadcast,
    output logic [dispatch_pkg::ADDR_WIDTH-1:0]     o_dest_base
);

    import dispatch_pkg::*;

    // Enable level from the previous cycle
    logic disp_en_prev;
    // Rising edge seen while the sequencer is free
    logic accept;

    // Number of set bits in the column mask
    function automatic logic [TILE_IDX_WIDTH:0] popcount(input logic [NUM_TILES-1:0] bits);
        logic [TILE_IDX_WIDTH:0] count;
        count = '0;
        for (int i = 0; i < NUM_TILES; i++) begin
            count = count + bits[i];
        end
        return count;
    endfunction

    // Edges while busy are dropped here, the sequencer never sees them
    assign accept = i_disp_en && !disp_en_prev && i_idle;

    // ========================================
    // Edge detect and start pulse
    // ========================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            disp_en_prev <= 1'b0;
            o_start      <= 1'b0;
        end else begin
            disp_en_prev <= i_disp_en;
            // One-cycle pulse after the accepted edge
            o_start      <= accept;
        end
    end

    // ========================================
    // Command registers
    // ========================================
    // Held stable for the whole dispatch
    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_batch_lines   <= LINE_CNT_WIDTH'(i_disp_ugd_vec_size)
                               * LINE_CNT_WIDTH'(LINES_PER_NV);
            // NV count is a whole number of vectors
            o_total_batches <= i_disp_man_nv_cnt / i_disp_ugd_vec_size;
            o_num_tiles     <= popcount(i_disp_col_en);
            o_col_en        <= i_disp_col_en;
            o_broadcast     <= i_disp_broadcast;
            o_dest_base     <= i_disp_tile_addr;
        end
    end

endmodule : dispatch_cmd_capture

// ==== logic/dispatch_pkg.sv ====
// Dispatch package with shared widths, tile count and sequencer state codes
package dispatch_pkg;

    // ========================================
    // Data path widths
    // ========================================
    // Mantissa line
    localparam int MAN_WIDTH = 256;
    // Exponent line
    localparam int EXP_WIDTH = 8;
    // Dispatcher and tile memories hold 512 lines
    localparam int ADDR_WIDTH = 9;

    // ========================================
    // Tile array and command fields
    // ========================================
    // One mask bit and one write enable per tile column
    localparam int NUM_TILES = 24;
    localparam int TILE_IDX_WIDTH = 5;
    // NV count and vector size fields
    localparam int NV_CNT_WIDTH = 8;
    // Each NV spans four memory lines
    localparam int LINES_PER_NV = 4;
    localparam int LINE_CNT_WIDTH = 10;

    // ========================================
    // Sequencer states
    // ========================================
    localparam int STATE_WIDTH = 2;
    localparam logic [STATE_WIDTH-1:0] ST_IDLE = 2'd0;
    localparam logic [STATE_WIDTH-1:0] ST_BUSY = 2'd1;
    localparam logic [STATE_WIDTH-1:0] ST_DONE = 2'd2;

endpackage : dispatch_pkg
